//--- common/bp_cplx_cfg.svh
`ifndef BP_CPLX_CFG_SVH
`define BP_CPLX_CFG_SVH

////////////////////
// complex size and widths
`define BP_NUM_CORE     2
`define BP_CORD_WIDTH   4
`define BP_CID_WIDTH    2
`define BP_LEN_WIDTH    2
`define BP_FLIT_WIDTH   32
`define BP_ADDR_WIDTH   16

// scratchpad depth in words per tile
`define BP_SPAD_ELS     16

// tile that shares its port with the enclave
`define BP_MMIO_POS     0

////////////////////
// address map
`define BP_SPACE_MASK   16'hF000
`define BP_CFG_BASE     16'h0000
`define BP_SOFT_BASE    16'h1000
`define BP_CMP_BASE     16'h2000
`define BP_MTIME_ADDR   16'h3000
`define BP_STATUS_ADDR  16'hF000

`endif

//--- common/bp_mem_pkg.sv
`default_nettype none

`include "bp_cplx_cfg.svh"

package bp_mem_pkg;

  ////////////////////
  // memory message opcodes
  typedef enum logic [1:0]
  {
    e_mem_load       = 2'b00,
    e_mem_store      = 2'b01,
    e_mem_load_resp  = 2'b10,
    e_mem_store_resp = 2'b11
  } bp_mem_op_e;

  // decoded command held while a packet is being served
  // valid_data marks a payload that goes back in the response
  typedef struct packed
  {
    bp_mem_op_e                opcode;
    logic [`BP_ADDR_WIDTH-1:0] addr;
    logic [`BP_FLIT_WIDTH-1:0] data;
    logic [`BP_CID_WIDTH-1:0]  cid;
    logic                      valid_data;
  } bp_cmd_s;

  ////////////////////
  // configuration write from the enclave to one tile
  typedef struct packed
  {
    logic                      w_v;
    logic [`BP_ADDR_WIDTH-1:0] addr;
    logic [`BP_FLIT_WIDTH-1:0] data;
  } bp_cfg_s;

endpackage

`default_nettype wire

//--- common/bp_noc_pkg.sv
`default_nettype none

`include "bp_cplx_cfg.svh"

package bp_noc_pkg;

  import bp_mem_pkg::*;

  // header bits left over after the named fields
  localparam int unsigned bp_hdr_pad_width = `BP_FLIT_WIDTH - `BP_CORD_WIDTH
                                             - `BP_CID_WIDTH - `BP_LEN_WIDTH
                                             - $bits(bp_mem_op_e) - `BP_ADDR_WIDTH;

  ////////////////////
  // ready-and link, one per direction
  // ready_and belongs to the flow going the other way
  typedef struct packed
  {
    logic                      v;
    logic                      ready_and;
    logic [`BP_FLIT_WIDTH-1:0] data;
  } bp_link_s;

  ////////////////////
  // wormhole header flit
  // len counts the flits behind the header
  typedef struct packed
  {
    logic [`BP_CORD_WIDTH-1:0] cord;
    logic [`BP_CID_WIDTH-1:0]  cid;
    logic [`BP_LEN_WIDTH-1:0]  len;
    bp_mem_op_e                opcode;
    logic [`BP_ADDR_WIDTH-1:0] addr;
    logic [bp_hdr_pad_width-1:0] pad;
  } bp_flit_hdr_s;

endpackage

`default_nettype wire

//--- tile/bp_tile_node.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_cplx_cfg.svh"

module bp_tile_node
  import bp_noc_pkg::*;
  import bp_mem_pkg::*;
  #(parameter int unsigned core_p = 0)
  (
    input  wire logic     clk_i,
    input  wire logic     rst_i,

    input  wire bp_cfg_s  cfg_i,
    input  wire logic     soft_irq_i,
    input  wire logic     timer_irq_i,

    input  wire bp_link_s cmd_link_i,
    output bp_link_s      cmd_link_o,
    input  wire bp_link_s resp_link_i,
    output bp_link_s      resp_link_o
  );

  typedef enum logic [1:0]
  {
    e_idle,
    e_data,
    e_resp_hdr,
    e_resp_data
  } bp_tile_state_e;

  localparam int unsigned spad_idx_width_lp = $clog2(`BP_SPAD_ELS);
  localparam logic [`BP_CORD_WIDTH-1:0] my_cord_lp = core_p[`BP_CORD_WIDTH-1:0];

  bp_tile_state_e state_r, state_n;
  bp_cmd_s        cmd_r;
  bp_flit_hdr_s   cmd_hdr, resp_hdr;

  logic [`BP_FLIT_WIDTH-1:0] spad_r [`BP_SPAD_ELS];
  logic [`BP_FLIT_WIDTH-1:0] load_data;
  logic freeze_r;
  logic cmd_ready, cmd_hs, resp_hs, spad_w_v;

  assign cmd_hdr   = bp_flit_hdr_s'(cmd_link_i.data);
  assign cmd_ready = (state_r == e_idle) || (state_r == e_data);
  assign cmd_hs    = cmd_ready & cmd_link_i.v;
  assign resp_hs   = resp_link_o.v & resp_link_i.ready_and;

  // status word or scratchpad word, sampled when the header lands
  assign load_data = (cmd_hdr.addr == `BP_STATUS_ADDR)
                   ? {{(`BP_FLIT_WIDTH-3){1'b0}}, timer_irq_i, soft_irq_i, freeze_r}
                   : spad_r[cmd_hdr.addr[spad_idx_width_lp-1:0]];

  // frozen stores are dropped here but still answered
  assign spad_w_v = (state_r == e_data) && cmd_hs && !freeze_r
                    && (cmd_r.addr != `BP_STATUS_ADDR);

  ////////////////////
  // packet FSM
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (cmd_hs)
          state_n = (cmd_hdr.len != '0) ? e_data : e_resp_hdr;
      e_data:
        if (cmd_hs)
          state_n = e_resp_hdr;
      e_resp_hdr:
        if (resp_hs)
          state_n = cmd_r.valid_data ? e_resp_data : e_idle;
      default:
        if (resp_hs)
          state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      freeze_r <= 1'b0;
    else if (cfg_i.w_v && (cfg_i.addr == '0))
      freeze_r <= cfg_i.data[0];
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_r == e_idle) && cmd_hs)
    begin
      cmd_r.opcode     <= cmd_hdr.opcode;
      cmd_r.addr       <= cmd_hdr.addr;
      cmd_r.cid        <= cmd_hdr.cid;
      cmd_r.valid_data <= (cmd_hdr.opcode == e_mem_load);
      cmd_r.data       <= load_data;
    end
    if (spad_w_v)
      spad_r[cmd_r.addr[spad_idx_width_lp-1:0]] <= cmd_link_i.data;
  end

  ////////////////////
  // link outputs
  always_comb
  begin
    resp_hdr        = '0;
    resp_hdr.cord   = my_cord_lp;
    resp_hdr.cid    = cmd_r.cid;
    resp_hdr.len    = cmd_r.valid_data ? `BP_LEN_WIDTH'(1) : '0;
    resp_hdr.opcode = cmd_r.valid_data ? e_mem_load_resp : e_mem_store_resp;
    resp_hdr.addr   = cmd_r.addr;

    resp_link_o.v         = (state_r == e_resp_hdr) || (state_r == e_resp_data);
    resp_link_o.data      = (state_r == e_resp_data) ? cmd_r.data : resp_hdr;
    // the tile never takes responses in
    resp_link_o.ready_and = 1'b0;

    cmd_link_o.v         = 1'b0;
    cmd_link_o.data      = '0;
    cmd_link_o.ready_and = cmd_ready;
  end

endmodule

`default_nettype wire

//--- concentrator/bp_wormhole_concentrator.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_cplx_cfg.svh"

module bp_wormhole_concentrator
  import bp_noc_pkg::*;
  (
    input  wire logic           clk_i,
    input  wire logic           rst_i,

    // index 0 is the tile side, index 1 the enclave side
    input  wire bp_link_s [1:0] links_i,
    output bp_link_s      [1:0] links_o,

    input  wire bp_link_s       concentrated_link_i,
    output bp_link_s            concentrated_link_o
  );

  bp_flit_hdr_s out_hdr, in_hdr;

  logic                     out_lock_v_r, out_lock_sel_r, rr_last_r;
  logic [`BP_LEN_WIDTH-1:0] out_cnt_r;
  logic                     out_sel, out_hs;

  logic                     in_lock_v_r, in_lock_sel_r;
  logic [`BP_LEN_WIDTH-1:0] in_cnt_r;
  logic                     in_sel, in_hs;

  ////////////////////
  // outbound merge
  always_comb
  begin
    if (out_lock_v_r)
      out_sel = out_lock_sel_r;
    else if (links_i[0].v && links_i[1].v)
      out_sel = ~rr_last_r;
    else
      out_sel = links_i[1].v;
  end

  assign out_hdr = bp_flit_hdr_s'(links_i[out_sel].data);
  assign out_hs  = concentrated_link_o.v & concentrated_link_i.ready_and;

  // lock holds the winner from header to last flit
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      out_lock_v_r   <= 1'b0;
      out_lock_sel_r <= 1'b0;
      out_cnt_r      <= '0;
      rr_last_r      <= 1'b1;
    end
    else if (out_hs)
    begin
      if (!out_lock_v_r)
      begin
        rr_last_r      <= out_sel;
        out_lock_sel_r <= out_sel;
        out_lock_v_r   <= (out_hdr.len != '0);
        out_cnt_r      <= out_hdr.len;
      end
      else
      begin
        out_cnt_r    <= out_cnt_r - 1'b1;
        out_lock_v_r <= (out_cnt_r != `BP_LEN_WIDTH'(1));
      end
    end
  end

  ////////////////////
  // inbound split
  assign in_hdr = bp_flit_hdr_s'(concentrated_link_i.data);
  // cid 0 goes to the tile, anything else to the enclave
  assign in_sel = in_lock_v_r ? in_lock_sel_r : (in_hdr.cid != '0);
  assign in_hs  = concentrated_link_i.v & concentrated_link_o.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      in_lock_v_r   <= 1'b0;
      in_lock_sel_r <= 1'b0;
      in_cnt_r      <= '0;
    end
    else if (in_hs)
    begin
      if (!in_lock_v_r)
      begin
        in_lock_sel_r <= in_sel;
        in_lock_v_r   <= (in_hdr.len != '0);
        in_cnt_r      <= in_hdr.len;
      end
      else
      begin
        in_cnt_r    <= in_cnt_r - 1'b1;
        in_lock_v_r <= (in_cnt_r != `BP_LEN_WIDTH'(1));
      end
    end
  end

  ////////////////////
  // zero latency muxing
  always_comb
  begin
    concentrated_link_o.v         = links_i[out_sel].v;
    concentrated_link_o.data      = links_i[out_sel].data;
    concentrated_link_o.ready_and = links_i[in_sel].ready_and;

    for (int k = 0; k < 2; k++)
    begin
      links_o[k].v         = concentrated_link_i.v && (in_sel == k);
      links_o[k].data      = concentrated_link_i.data;
      links_o[k].ready_and = concentrated_link_i.ready_and && (out_sel == k);
    end
  end

endmodule

`default_nettype wire

//--- mmio/bp_mmio_enclave.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_cplx_cfg.svh"

module bp_mmio_enclave
  import bp_noc_pkg::*;
  import bp_mem_pkg::*;
  (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,

    input  wire bp_link_s             cmd_link_i,
    output bp_link_s                  cmd_link_o,
    input  wire bp_link_s             resp_link_i,
    output bp_link_s                  resp_link_o,

    output bp_cfg_s [`BP_NUM_CORE-1:0] cfg_o,
    output logic    [`BP_NUM_CORE-1:0] soft_irq_o,
    output logic    [`BP_NUM_CORE-1:0] timer_irq_o
  );

  typedef enum logic [1:0]
  {
    e_idle,
    e_data,
    e_resp_hdr,
    e_resp_data
  } bp_mmio_state_e;

  localparam int unsigned core_idx_width_lp = (`BP_NUM_CORE > 1) ? $clog2(`BP_NUM_CORE) : 1;
  localparam int unsigned mmio_pos_lp = `BP_MMIO_POS;

  bp_mmio_state_e state_r, state_n;
  bp_cmd_s        cmd_r;
  bp_flit_hdr_s   cmd_hdr, resp_hdr;

  logic [`BP_FLIT_WIDTH-1:0]                   mtime_r, load_data;
  logic [`BP_NUM_CORE-1:0][`BP_FLIT_WIDTH-1:0] mtimecmp_r;
  logic [`BP_NUM_CORE-1:0]                     soft_irq_r, cfg_w_v_r;
  logic [`BP_ADDR_WIDTH-1:0]                   cfg_addr_r, space;
  logic [`BP_FLIT_WIDTH-1:0]                   cfg_data_r;
  logic cmd_ready, cmd_hs, resp_hs, store_v;

  assign cmd_hdr   = bp_flit_hdr_s'(cmd_link_i.data);
  assign cmd_ready = (state_r == e_idle) || (state_r == e_data);
  assign cmd_hs    = cmd_ready & cmd_link_i.v;
  assign resp_hs   = resp_link_o.v & resp_link_i.ready_and;
  assign store_v   = (state_r == e_data) && cmd_hs;
  assign space     = cmd_r.addr & `BP_SPACE_MASK;

  // read value taken at header time so it holds under back-pressure
  always_comb
  begin
    load_data = '0;
    if (cmd_hdr.addr == `BP_MTIME_ADDR)
      load_data = mtime_r;
    else if ((cmd_hdr.addr & `BP_SPACE_MASK) == `BP_CMP_BASE)
      load_data = mtimecmp_r[cmd_hdr.addr[core_idx_width_lp-1:0]];
  end

  ////////////////////
  // packet FSM
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (cmd_hs)
          state_n = (cmd_hdr.len != '0) ? e_data : e_resp_hdr;
      e_data:
        if (cmd_hs)
          state_n = e_resp_hdr;
      e_resp_hdr:
        if (resp_hs)
          state_n = cmd_r.valid_data ? e_resp_data : e_idle;
      default:
        if (resp_hs)
          state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r    <= e_idle;
      mtime_r    <= '0;
      soft_irq_r <= '0;
      cfg_w_v_r  <= '0;
      mtimecmp_r <= '1;
    end
    else
    begin
      state_r <= state_n;
      mtime_r <= mtime_r + 1'b1;
      for (int c = 0; c < `BP_NUM_CORE; c++)
      begin
        // cfg strobe lasts one cycle, core picked by bits 11:8
        cfg_w_v_r[c] <= store_v && (space == `BP_CFG_BASE) && (cmd_r.addr[11:8] == c);
        if (store_v && (space == `BP_SOFT_BASE)
            && (cmd_r.addr[core_idx_width_lp-1:0] == c))
          soft_irq_r[c] <= cmd_link_i.data[0];
        if (store_v && (space == `BP_CMP_BASE)
            && (cmd_r.addr[core_idx_width_lp-1:0] == c))
          mtimecmp_r[c] <= cmd_link_i.data;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_r == e_idle) && cmd_hs)
    begin
      cmd_r.opcode     <= cmd_hdr.opcode;
      cmd_r.addr       <= cmd_hdr.addr;
      cmd_r.cid        <= cmd_hdr.cid;
      cmd_r.valid_data <= (cmd_hdr.opcode == e_mem_load);
      cmd_r.data       <= load_data;
    end
    if (store_v)
    begin
      cfg_addr_r <= {8'h00, cmd_r.addr[7:0]};
      cfg_data_r <= cmd_link_i.data;
    end
  end

  ////////////////////
  // outputs
  always_comb
  begin
    for (int c = 0; c < `BP_NUM_CORE; c++)
    begin
      cfg_o[c].w_v   = cfg_w_v_r[c];
      cfg_o[c].addr  = cfg_addr_r;
      cfg_o[c].data  = cfg_data_r;
      timer_irq_o[c] = (mtime_r >= mtimecmp_r[c]);
    end
    soft_irq_o = soft_irq_r;

    resp_hdr        = '0;
    resp_hdr.cord   = mmio_pos_lp[`BP_CORD_WIDTH-1:0];
    resp_hdr.cid    = cmd_r.cid;
    resp_hdr.len    = cmd_r.valid_data ? `BP_LEN_WIDTH'(1) : '0;
    resp_hdr.opcode = cmd_r.valid_data ? e_mem_load_resp : e_mem_store_resp;
    resp_hdr.addr   = cmd_r.addr;

    resp_link_o.v         = (state_r == e_resp_hdr) || (state_r == e_resp_data);
    resp_link_o.data      = (state_r == e_resp_data) ? cmd_r.data : resp_hdr;
    resp_link_o.ready_and = 1'b0;

    cmd_link_o.v         = 1'b0;
    cmd_link_o.data      = '0;
    cmd_link_o.ready_and = cmd_ready;
  end

endmodule

`default_nettype wire

//--- source/bp_core_complex.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_cplx_cfg.svh"

module bp_core_complex
  import bp_noc_pkg::*;
  import bp_mem_pkg::*;
  (
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,

    input  wire bp_link_s [`BP_NUM_CORE-1:0]   cmd_link_i,
    output bp_link_s      [`BP_NUM_CORE-1:0]   cmd_link_o,

    input  wire bp_link_s [`BP_NUM_CORE-1:0]   resp_link_i,
    output bp_link_s      [`BP_NUM_CORE-1:0]   resp_link_o
  );

  bp_cfg_s [`BP_NUM_CORE-1:0] cfg_lo;
  logic    [`BP_NUM_CORE-1:0] soft_irq_lo;
  logic    [`BP_NUM_CORE-1:0] timer_irq_lo;

  wire bp_link_s [`BP_NUM_CORE-1:0] tile_cmd_link_li;
  wire bp_link_s [`BP_NUM_CORE-1:0] tile_cmd_link_lo;
  wire bp_link_s [`BP_NUM_CORE-1:0] tile_resp_link_li;
  wire bp_link_s [`BP_NUM_CORE-1:0] tile_resp_link_lo;

  wire bp_link_s mmio_cmd_link_li;
  wire bp_link_s mmio_cmd_link_lo;
  wire bp_link_s mmio_resp_link_li;
  wire bp_link_s mmio_resp_link_lo;

  bp_mmio_enclave mmio
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_link_i  (mmio_cmd_link_li),
    .cmd_link_o  (mmio_cmd_link_lo),
    .resp_link_i (mmio_resp_link_li),
    .resp_link_o (mmio_resp_link_lo),
    .cfg_o       (cfg_lo),
    .soft_irq_o  (soft_irq_lo),
    .timer_irq_o (timer_irq_lo)
  );

  for (genvar i = 0; i < `BP_NUM_CORE; i++)
  begin : core
    bp_tile_node #(.core_p(i)) tile
    (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cfg_i       (cfg_lo[i]),
      .soft_irq_i  (soft_irq_lo[i]),
      .timer_irq_i (timer_irq_lo[i]),
      .cmd_link_i  (tile_cmd_link_li[i]),
      .cmd_link_o  (tile_cmd_link_lo[i]),
      .resp_link_i (tile_resp_link_li[i]),
      .resp_link_o (tile_resp_link_lo[i])
    );

    if (i == `BP_MMIO_POS)
    begin : conc
      // index 0 is the tile, index 1 the enclave
      bp_link_s [1:0] cmd_local_li, cmd_local_lo;
      bp_link_s [1:0] resp_local_li, resp_local_lo;

      assign cmd_local_li  = {mmio_cmd_link_lo, tile_cmd_link_lo[i]};
      assign resp_local_li = {mmio_resp_link_lo, tile_resp_link_lo[i]};
      assign {mmio_cmd_link_li, tile_cmd_link_li[i]}   = cmd_local_lo;
      assign {mmio_resp_link_li, tile_resp_link_li[i]} = resp_local_lo;

      bp_wormhole_concentrator cmd_concentrator
      (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .links_i             (cmd_local_li),
        .links_o             (cmd_local_lo),
        .concentrated_link_i (cmd_link_i[i]),
        .concentrated_link_o (cmd_link_o[i])
      );

      bp_wormhole_concentrator resp_concentrator
      (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .links_i             (resp_local_li),
        .links_o             (resp_local_lo),
        .concentrated_link_i (resp_link_i[i]),
        .concentrated_link_o (resp_link_o[i])
      );
    end
    else
    begin : no_conc
      assign tile_cmd_link_li[i]  = cmd_link_i[i];
      assign cmd_link_o[i]        = tile_cmd_link_lo[i];
      assign tile_resp_link_li[i] = resp_link_i[i];
      assign resp_link_o[i]       = tile_resp_link_lo[i];
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_core_complex.sv
`timescale 1ns/100ps
`default_nettype none

`include "bp_cplx_cfg.svh"

module tb_core_complex
  import bp_noc_pkg::*;
  import bp_mem_pkg::*;
  ();

  localparam int unsigned wait_limit_lp = 200;

  logic clk;
  logic rst;

  bp_link_s [`BP_NUM_CORE-1:0] cmd_li;
  bp_link_s [`BP_NUM_CORE-1:0] cmd_lo;
  bp_link_s [`BP_NUM_CORE-1:0] resp_li;
  bp_link_s [`BP_NUM_CORE-1:0] resp_lo;

  int          errors;
  int          checks;
  logic [31:0] lcg_state;

  bp_core_complex dut0
  (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_link_i  (cmd_li),
    .cmd_link_o  (cmd_lo),
    .resp_link_i (resp_li),
    .resp_link_o (resp_lo)
  );

  always
  begin
    #4 clk = ~clk;
  end

  ////////////////////
  // helpers
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] make_hdr(input int core, input int cid,
                                           input bp_mem_op_e op, input logic [15:0] addr);
    bp_flit_hdr_s hdr;
    hdr        = '0;
    hdr.cord   = core[`BP_CORD_WIDTH-1:0];
    hdr.cid    = cid[`BP_CID_WIDTH-1:0];
    // a store carries one data flit behind the header
    hdr.len    = (op == e_mem_store) ? `BP_LEN_WIDTH'(1) : '0;
    hdr.opcode = op;
    hdr.addr   = addr;
    return hdr;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout, %s", what);
  endtask

  // called on a falling edge and returns on the one after the handshake
  task automatic send_flit(input int core, input logic [31:0] flit);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    cmd_li[core].v    = 1'b1;
    cmd_li[core].data = flit;
    while (!taken && waited < wait_limit_lp)
    begin
      #1;
      taken = cmd_lo[core].ready_and;
      @(negedge clk);
      waited++;
    end
    cmd_li[core].v = 1'b0;
    if (!taken)
      report_timeout("the command link never accepted a flit");
  endtask

  task automatic recv_flit(input int core, output logic [31:0] flit);
    int          waited;
    int          stalls;
    logic        done;
    logic        held_v;
    logic [31:0] held;
    waited = 0;
    stalls = 0;
    done   = 1'b0;
    held_v = 1'b0;
    held   = '0;
    flit   = '0;
    while (!done && waited < wait_limit_lp)
    begin
      lcg_state = lcg_next(lcg_state);
      // random stalls of at most three cycles in a row
      resp_li[core].ready_and = (lcg_state[17:16] != 2'b00) || (stalls >= 3);
      #1;
      if (held_v)
      begin
        check_value("stalled resp valid", 1, resp_lo[core].v);
        check_value("stalled resp data", held, resp_lo[core].data);
      end
      held_v = resp_lo[core].v && !resp_li[core].ready_and;
      held   = resp_lo[core].data;
      done   = resp_lo[core].v && resp_li[core].ready_and;
      flit   = resp_lo[core].data;
      if (resp_li[core].ready_and)
        stalls = 0;
      else
        stalls++;
      @(negedge clk);
      waited++;
    end
    resp_li[core].ready_and = 1'b0;
    if (!done)
      report_timeout("no response flit arrived");
  endtask

  // one command packet and its whole response
  task automatic run_op(input string name, input bit is_store, input int core, input int cid,
                        input logic [15:0] addr, input logic [31:0] wdata,
                        input bit check_rd, input logic [31:0] exp,
                        output logic [31:0] rdata);
    logic [31:0]  flit;
    bp_flit_hdr_s hdr;
    rdata = '0;
    send_flit(core, make_hdr(core, cid, is_store ? e_mem_store : e_mem_load, addr));
    if (is_store)
      send_flit(core, wdata);
    recv_flit(core, flit);
    hdr = bp_flit_hdr_s'(flit);
    check_value({name, " cid"}, cid, hdr.cid);
    if (is_store)
      check_value({name, " opcode"}, e_mem_store_resp, hdr.opcode);
    else
    begin
      check_value({name, " opcode"}, e_mem_load_resp, hdr.opcode);
      recv_flit(core, rdata);
      if (check_rd)
        check_value(name, exp, rdata);
    end
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    int           fd;
    int           n;
    int           core;
    int           cid;
    int           vec_count;
    logic [63:0]  op;
    logic [639:0] line;
    logic [15:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  exp;
    logic [31:0]  rdata;
    logic [31:0]  t0;
    logic [31:0]  t1;
    logic [31:0]  flit;
    logic [3:0]   seen;
    bp_flit_hdr_s hdr;
    string        name;

    errors    = 0;
    checks    = 0;
    vec_count = 0;
    lcg_state = 32'h039ebc62;
    clk       = 1'b0;
    rst       = 1'b1;
    cmd_li    = '0;
    resp_li   = '0;

    repeat (5) @(negedge clk);
    rst = 1'b0;

    for (int c = 0; c < `BP_NUM_CORE; c++)
    begin
      check_value("resp valid after reset", 0, resp_lo[c].v);
      check_value("cmd valid after reset", 0, cmd_lo[c].v);
    end

    fd = $fopen("sim/core_complex_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("could not open sim/core_complex_vectors.txt");
      errors++;
    end
    else
    begin
      while ($fscanf(fd, "%s", op) == 1)
      begin
        if (op == "#")
          n = $fgets(line, fd);
        else
        begin
          n = $fscanf(fd, "%d %d %h %h %h", core, cid, addr, wdata, exp);
          if (n != 5 || (op != "ld" && op != "st"))
          begin
            $display("a vector line could not be understood");
            errors++;
          end
          else
          begin
            vec_count++;
            name = $sformatf("vector %0d %s core %0d cid %0d addr %h", vec_count,
                             (op == "st") ? "store" : "load", core, cid, addr);
            run_op(name, op == "st", core, cid, addr, wdata, 1'b1, exp, rdata);
          end
        end
      end
      $fclose(fd);
      if (vec_count == 0)
      begin
        $display("the vector file held no transactions");
        errors++;
      end

      // mtime keeps counting between two reads
      run_op("mtime first", 1'b0, `BP_MMIO_POS, 1, `BP_MTIME_ADDR, '0, 1'b0, '0, t0);
      run_op("mtime second", 1'b0, `BP_MMIO_POS, 1, `BP_MTIME_ADDR, '0, 1'b0, '0, t1);
      check_value("mtime increases", 1, t1 > t0);

      // tile and enclave loads queued together at the shared port
      seen = '0;
      send_flit(`BP_MMIO_POS, make_hdr(`BP_MMIO_POS, 0, e_mem_load, 16'h0003));
      send_flit(`BP_MMIO_POS, make_hdr(`BP_MMIO_POS, 1, e_mem_load, `BP_CMP_BASE));
      for (int p = 0; p < 2; p++)
      begin
        recv_flit(`BP_MMIO_POS, flit);
        hdr = bp_flit_hdr_s'(flit);
        check_value("merged header opcode", e_mem_load_resp, hdr.opcode);
        seen[hdr.cid] = 1'b1;
        recv_flit(`BP_MMIO_POS, flit);
        check_value("merged data follows header",
                    (hdr.cid == 0) ? 32'h11111111 : 32'hffffffff, flit);
      end
      check_value("merged cids", 4'b0011, seen);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/core_complex_vectors.txt
# op core cid addr wdata expected, addr wdata expected in hex
# cid 1 reaches the MMIO enclave through the port of core 0
st 0 0 0003 11111111 00000000
st 1 0 0003 22222222 00000000
ld 0 0 0003 00000000 11111111
ld 1 0 0003 00000000 22222222
st 0 0 0005 a5a5a5a5 00000000
ld 0 0 0015 00000000 a5a5a5a5
ld 0 1 2000 00000000 ffffffff
ld 0 1 2001 00000000 ffffffff
ld 0 0 f000 00000000 00000000
st 0 1 0000 00000001 00000000
ld 0 0 f000 00000000 00000001
st 0 0 0003 deadbeef 00000000
ld 0 0 0003 00000000 11111111
st 1 0 0003 33333333 00000000
ld 1 0 0003 00000000 33333333
ld 1 0 f000 00000000 00000000
st 0 1 1001 00000001 00000000
ld 1 0 f000 00000000 00000002
st 0 1 1001 00000000 00000000
ld 1 0 f000 00000000 00000000
st 0 1 2001 00000000 00000000
ld 0 1 2001 00000000 00000000
ld 1 0 f000 00000000 00000004
st 0 1 0000 00000000 00000000
ld 0 0 f000 00000000 00000000

//--- vlog.f
+incdir+common
common/bp_mem_pkg.sv
common/bp_noc_pkg.sv
tile/bp_tile_node.sv
concentrator/bp_wormhole_concentrator.sv
mmio/bp_mmio_enclave.sv
source/bp_core_complex.sv
sim/tb_core_complex.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_core_complex -f vlog.f -o sim_core_complex

./obj_dir/sim_core_complex > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
